// ==== tage_lite.f ====
hw/bp_cfg_pkg.sv
hw/bp_types_pkg.sv
hw/bp_table_if.sv
hw/history_fold.sv
hw/base_table.sv
hw/tagged_table.sv
hw/inflight_buffer.sv
hw/tage_control.sv
hw/tage_predictor.sv
tb/tb_tage.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = tb_tage
FILELIST = tage_lite.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb/tb_tage.sv ====
// Simulation top for tage_predictor with directed and random traffic checked against a model
`timescale 1ns/1ps

module tb_tage
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
();

    localparam int N_RANDOM  = 3000;
    localparam int POLL_MAX  = 400;
    localparam int POOL_SIZE = 12;
    localparam logic [PC_W-1:0] DIR_PC = 32'h0000_4a5c;

    logic            clk;
    logic            rst_n;
    logic            predict_valid_i;
    logic [PC_W-1:0] pc_i;
    logic            update_valid_i;
    logic [PC_W-1:0] update_pc_i;
    logic            update_taken_i;
    logic            taken_o;
    logic [1:0]      provider_o;

    // Reference model tables and history
    logic [BASE_CTR_W-1:0] m_base [2**BASE_IDX_W];
    logic [CTR_W-1:0]      m_ctr  [2][2**TBL_IDX_W];
    logic [TAG_W-1:0]      m_tag  [2][2**TBL_IDX_W];
    logic [USE_W-1:0]      m_use  [2][2**TBL_IDX_W];
    logic [GHR_W-1:0]      m_ghr;

    // Model of the pending records with slot 0 the youngest
    logic                 b_valid [BUF_DEPTH];
    logic [PC_W-1:0]      b_pc    [BUF_DEPTH];
    logic [TBL_IDX_W-1:0] b_idx   [BUF_DEPTH][2];
    logic [TAG_W-1:0]     b_tag   [BUF_DEPTH][2];
    int                   b_prov  [BUF_DEPTH];
    logic                 b_ppred [BUF_DEPTH];
    logic                 b_alt   [BUF_DEPTH];

    // Lookup of the current cycle
    logic [TBL_IDX_W-1:0] q_idx [2];
    logic [TAG_W-1:0]     q_tag [2];
    int                   exp_prov;
    logic                 exp_taken;
    logic                 exp_alt;
    logic                 act_taken;
    logic [1:0]           act_prov;

    logic [31:0]     rng;
    logic [PC_W-1:0] pc_pool     [POOL_SIZE];
    int              recent_slot [16];
    logic            recent_v    [16];
    int              both_cycles;
    int              prov_count  [3];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    tage_predictor uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .predict_valid_i (predict_valid_i),
        .pc_i            (pc_i),
        .update_valid_i  (update_valid_i),
        .update_pc_i     (update_pc_i),
        .update_taken_i  (update_taken_i),
        .taken_o         (taken_o),
        .provider_o      (provider_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Chunks of out_len bits XORed together with the top chunk zero padded
    function automatic logic [7:0] fold(input logic [GHR_W-1:0] hist, input int len,
                                        input int out_len);
        logic [31:0] h;
        logic [31:0] acc;
        h   = 32'(hist) & ((32'd1 << len) - 1);
        acc = '0;
        for (int used = 0; used < len; used += out_len) begin
            acc = acc ^ (h & ((32'd1 << out_len) - 1));
            h   = h >> out_len;
        end
        return acc[7:0];
    endfunction

    function automatic int hist_len(input int t);
        return (t == 0) ? T1_HIST : T2_HIST;
    endfunction

    function automatic logic [TBL_IDX_W-1:0] table_index(input int t, input logic [PC_W-1:0] pc);
        logic [7:0] f;
        f = fold(m_ghr, hist_len(t), TBL_IDX_W);
        return f[TBL_IDX_W-1:0] ^ pc[TBL_IDX_W-1:0] ^ pc[2*TBL_IDX_W-1:TBL_IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] table_tag(input int t, input logic [PC_W-1:0] pc);
        logic [7:0] f8;
        logic [7:0] f7;
        f8 = fold(m_ghr, hist_len(t), TAG_W);
        f7 = fold(m_ghr, hist_len(t), TAG_W - 1);
        return pc[TAG_W-1:0] ^ f8 ^ (f7 << 1);
    endfunction

    function automatic int sat_step(input int v, input int maxv, input logic up);
        if (up && v < maxv) begin
            return v + 1;
        end
        if (!up && v > 0) begin
            return v - 1;
        end
        return v;
    endfunction

    // True when the model buffer holds a live record for this PC
    function automatic logic record_pending(input logic [PC_W-1:0] upc);
        logic found;
        found = 1'b0;
        for (int k = 0; k < BUF_DEPTH; k++) begin
            if (b_valid[k] && b_pc[k] == upc) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Branch bias depends on the PC slot
    function automatic logic pick_outcome(input int slot);
        logic [31:0] r;
        r = next_rand();
        case (slot % 3)
            0:       return r[3:0] != 4'd0;
            1:       return r[3:0] == 4'd0;
            default: return r[0];
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Polls at half-ns offsets from the clock edges
    task automatic wait_fall();
        int n;
        n = 0;
        while (clk !== 1'b1 && n < POLL_MAX) begin
            #1;
            n++;
        end
        while (clk !== 1'b0 && n < POLL_MAX) begin
            #1;
            n++;
        end
        if (n >= POLL_MAX) begin
            $display("Timed out waiting for a falling clock edge");
            $display("Simulation failed");
            $fatal(1, "clock stalled");
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < 2**BASE_IDX_W; i++) begin
            m_base[i] = 2'b10;
        end
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < 2**TBL_IDX_W; i++) begin
                m_ctr[t][i] = 3'b100;
                m_tag[t][i] = '0;
                m_use[t][i] = '0;
            end
        end
        for (int k = 0; k < BUF_DEPTH; k++) begin
            b_valid[k] = 1'b0;
        end
        m_ghr = '0;
    endtask

    task automatic model_lookup(input logic [PC_W-1:0] pc);
        logic hit  [2];
        logic pred [2];
        logic base_p;
        base_p = m_base[pc[BASE_IDX_W-1:0]][BASE_CTR_W-1];
        for (int t = 0; t < 2; t++) begin
            q_idx[t] = table_index(t, pc);
            q_tag[t] = table_tag(t, pc);
            hit[t]   = (m_tag[t][q_idx[t]] == q_tag[t]);
            pred[t]  = m_ctr[t][q_idx[t]][CTR_W-1];
        end
        exp_prov  = PROV_BASE;
        exp_taken = base_p;
        exp_alt   = base_p;
        if (hit[1]) begin
            exp_prov  = PROV_T2;
            exp_taken = pred[1];
            exp_alt   = hit[0] ? pred[0] : base_p;
        end else if (hit[0]) begin
            exp_prov  = PROV_T1;
            exp_taken = pred[0];
        end
    endtask

    task automatic model_train(input logic [PC_W-1:0] upc, input logic taken);
        int                    s;
        int                    t;
        int                    prov;
        logic                  mis;
        logic [USE_W-1:0]      use0;
        logic [USE_W-1:0]      use1;
        logic [TBL_IDX_W-1:0]  i;
        logic [BASE_IDX_W-1:0] bi;
        s = -1;
        for (int k = BUF_DEPTH - 1; k >= 0; k--) begin
            if (b_valid[k] && b_pc[k] == upc) begin
                s = k;
            end
        end
        if (s < 0) begin
            return;
        end
        prov = b_prov[s];
        mis  = (b_ppred[s] != taken);
        use0 = m_use[0][b_idx[s][0]];
        use1 = m_use[1][b_idx[s][1]];
        if (prov == PROV_BASE) begin
            bi = upc[BASE_IDX_W-1:0];
            m_base[bi] = BASE_CTR_W'(sat_step(int'(m_base[bi]), 3, taken));
        end else begin
            t = prov - 1;
            i = b_idx[s][t];
            m_ctr[t][i] = CTR_W'(sat_step(int'(m_ctr[t][i]), 7, taken));
            if (b_ppred[s] != b_alt[s]) begin
                m_use[t][i] = USE_W'(sat_step(int'(m_use[t][i]), 3, !mis));
            end
        end
        // First longer table whose entry is not useful gets the new entry
        t = -1;
        if (mis && prov == PROV_BASE) begin
            t = (use0 == 0) ? 0 : ((use1 == 0) ? 1 : -1);
        end else if (mis && prov == PROV_T1 && use1 == 0) begin
            t = 1;
        end
        if (t >= 0 && m_tag[t][b_idx[s][t]] != b_tag[s][t]) begin
            i = b_idx[s][t];
            m_tag[t][i] = b_tag[s][t];
            m_ctr[t][i] = 3'b100;
            m_use[t][i] = '0;
        end
    endtask

    task automatic model_advance(input logic pv, input logic [PC_W-1:0] pc,
                                 input logic uv, input logic [PC_W-1:0] upc, input logic ut);
        if (uv) begin
            model_train(upc, ut);
        end
        for (int k = BUF_DEPTH - 1; k > 0; k--) begin
            b_valid[k] = b_valid[k-1];
            b_pc[k]    = b_pc[k-1];
            b_prov[k]  = b_prov[k-1];
            b_ppred[k] = b_ppred[k-1];
            b_alt[k]   = b_alt[k-1];
            for (int t = 0; t < 2; t++) begin
                b_idx[k][t] = b_idx[k-1][t];
                b_tag[k][t] = b_tag[k-1][t];
            end
        end
        b_valid[0] = pv;
        b_pc[0]    = pc;
        b_prov[0]  = exp_prov;
        b_ppred[0] = exp_taken;
        b_alt[0]   = exp_alt;
        for (int t = 0; t < 2; t++) begin
            b_idx[0][t] = q_idx[t];
            b_tag[0][t] = q_tag[t];
        end
        if (pv) begin
            m_ghr = {m_ghr[GHR_W-2:0], exp_taken};
        end
    endtask

    task automatic run_cycle(input string name, input logic pv, input logic [PC_W-1:0] pc,
                             input logic uv, input logic [PC_W-1:0] upc, input logic ut);
        wait_fall();
        predict_valid_i = pv;
        pc_i            = pc;
        update_valid_i  = uv;
        update_pc_i     = upc;
        update_taken_i  = ut;
        model_lookup(pc);
        #25;
        act_taken = taken_o;
        act_prov  = provider_o;
        check_value({name, "_provider"}, exp_prov, int'(act_prov));
        check_value({name, "_taken"}, int'(exp_taken), int'(act_taken));
        if (pv && uv && record_pending(upc)) begin
            both_cycles++;
        end
        if (pv) begin
            prov_count[exp_prov]++;
        end
        model_advance(pv, pc, uv, upc, ut);
    endtask

    initial begin
        logic [31:0]     r;
        logic            pv;
        logic            uv;
        logic            ut;
        logic [PC_W-1:0] upc;
        int              slot;
        int              d;
        int              back;
        rst_n           = 1'b0;
        predict_valid_i = 1'b0;
        pc_i            = '0;
        update_valid_i  = 1'b0;
        update_pc_i     = '0;
        update_taken_i  = 1'b0;
        rng             = 32'd40;
        both_cycles     = 0;
        for (int k = 0; k < 3; k++) begin
            prov_count[k] = 0;
        end
        for (int k = 0; k < 16; k++) begin
            recent_v[k] = 1'b0;
        end
        // Nonzero low bytes keep tags off cleared entries at zero history
        for (int k = 0; k < POOL_SIZE; k++) begin
            pc_pool[k] = 32'h0040_000c + k * 32'h0000_0344;
        end
        model_reset();
        #0.5;
        for (int k = 0; k < 16; k++) begin
            wait_fall();
        end
        rst_n = 1'b1;

        // Fresh tables give weak taken from the base table
        for (int k = 0; k < POOL_SIZE; k++) begin
            run_cycle("after_reset", 1'b0, pc_pool[k], 1'b0, '0, 1'b0);
            check_value("after_reset_provider", PROV_BASE, int'(act_prov));
            check_value("after_reset_taken", 1, int'(act_taken));
        end

        // Base mispredict followed by a second not-taken outcome
        run_cycle("base_first", 1'b1, DIR_PC, 1'b0, '0, 1'b0);
        check_value("base_first_taken", 1, int'(act_taken));
        run_cycle("base_update", 1'b0, DIR_PC, 1'b1, DIR_PC, 1'b0);
        run_cycle("base_again", 1'b1, DIR_PC, 1'b0, '0, 1'b0);
        run_cycle("base_update", 1'b0, DIR_PC, 1'b1, DIR_PC, 1'b0);
        run_cycle("base_trained", 1'b1, DIR_PC, 1'b0, '0, 1'b0);
        check_value("base_trained_provider", PROV_BASE, int'(act_prov));
        check_value("base_trained_taken", 0, int'(act_taken));

        // Shift zeros until the T1 history slice is back to zero
        for (int k = 0; k < 3; k++) begin
            run_cycle("history_walk", 1'b1, DIR_PC, 1'b0, '0, 1'b0);
        end
        run_cycle("t1_alloc", 1'b1, DIR_PC, 1'b0, '0, 1'b0);
        check_value("t1_alloc_provider", PROV_T1, int'(act_prov));
        check_value("t1_alloc_taken", 1, int'(act_taken));

        // Random traffic with late and stray updates
        for (int cyc = 0; cyc < N_RANDOM; cyc++) begin
            r    = next_rand();
            pv   = (r[1:0] != 2'b00);
            slot = int'(r[7:4]) % POOL_SIZE;
            uv   = r[8] | r[9];
            d    = 1 + int'(r[15:12]) % 10;
            back = (cyc - d) & 15;
            if (r[19:16] == 4'd0 || cyc < d || !recent_v[back]) begin
                upc = 32'h8000_0000 | {24'd0, r[27:20]};
                ut  = r[28];
            end else begin
                upc = pc_pool[recent_slot[back]];
                ut  = pick_outcome(recent_slot[back]);
            end
            recent_v[cyc & 15]    = pv;
            recent_slot[cyc & 15] = slot;
            run_cycle("random", pv, pc_pool[slot], uv, upc, ut);
        end

        if (both_cycles == 0) begin
            $display("No cycle carried a prediction and a matched update together");
            $display("Simulation failed");
            $fatal(1, "same-cycle case never exercised");
        end else begin
            $display("Providers seen: base %0d, T1 %0d, T2 %0d",
                     prov_count[0], prov_count[1], prov_count[2]);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== hw/tage_predictor.sv ====
// Top level of the tage_lite direction predictor with plain predict and update ports
`timescale 1ns/1ps

module tage_predictor
    import bp_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            predict_valid_i,
    input  logic [PC_W-1:0] pc_i,
    input  logic            update_valid_i,
    input  logic [PC_W-1:0] update_pc_i,
    input  logic            update_taken_i,
    output logic            taken_o,
    output logic [1:0]      provider_o
);

    logic [GHR_W-1:0]      ghr;
    logic                  base_pred;
    logic                  base_upd_valid;
    logic [BASE_IDX_W-1:0] base_upd_index;
    logic                  base_inc;
    logic                  t1_hit;
    logic                  t1_pred;
    logic [TBL_IDX_W-1:0]  t1_index;
    logic [TAG_W-1:0]      t1_tag;
    logic                  t2_hit;
    logic                  t2_pred;
    logic [TBL_IDX_W-1:0]  t2_index;
    logic [TAG_W-1:0]      t2_tag;

    bp_table_if t1_if ();
    bp_table_if t2_if ();

    tage_control u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .predict_valid_i  (predict_valid_i),
        .pc_i             (pc_i),
        .update_valid_i   (update_valid_i),
        .update_pc_i      (update_pc_i),
        .update_taken_i   (update_taken_i),
        .t1_hit_i         (t1_hit),
        .t1_pred_i        (t1_pred),
        .t1_index_i       (t1_index),
        .t1_tag_i         (t1_tag),
        .t2_hit_i         (t2_hit),
        .t2_pred_i        (t2_pred),
        .t2_index_i       (t2_index),
        .t2_tag_i         (t2_tag),
        .base_pred_i      (base_pred),
        .t1               (t1_if.ctrl),
        .t2               (t2_if.ctrl),
        .base_upd_valid_o (base_upd_valid),
        .base_upd_index_o (base_upd_index),
        .base_inc_o       (base_inc),
        .ghr_o            (ghr),
        .taken_o          (taken_o),
        .provider_o       (provider_o)
    );

    base_table u_base (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_i        (pc_i),
        .pred_o      (base_pred),
        .upd_valid_i (base_upd_valid),
        .upd_index_i (base_upd_index),
        .inc_i       (base_inc)
    );

    // Short and long history tables
    tagged_table #(.HIST_LEN(T1_HIST)) u_t1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ghr_i   (ghr[T1_HIST-1:0]),
        .pc_i    (pc_i),
        .hit_o   (t1_hit),
        .pred_o  (t1_pred),
        .index_o (t1_index),
        .tag_o   (t1_tag),
        .upd     (t1_if.tbl)
    );

    tagged_table #(.HIST_LEN(T2_HIST)) u_t2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ghr_i   (ghr[T2_HIST-1:0]),
        .pc_i    (pc_i),
        .hit_o   (t2_hit),
        .pred_o  (t2_pred),
        .index_o (t2_index),
        .tag_o   (t2_tag),
        .upd     (t2_if.tbl)
    );

endmodule

// ==== hw/tage_control.sv ====
// TAGE control with the global history, provider choice and the update and allocation policy
`timescale 1ns/1ps

module tage_control
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  predict_valid_i,
    input  logic [PC_W-1:0]       pc_i,
    input  logic                  update_valid_i,
    input  logic [PC_W-1:0]       update_pc_i,
    input  logic                  update_taken_i,
    input  logic                  t1_hit_i,
    input  logic                  t1_pred_i,
    input  logic [TBL_IDX_W-1:0]  t1_index_i,
    input  logic [TAG_W-1:0]      t1_tag_i,
    input  logic                  t2_hit_i,
    input  logic                  t2_pred_i,
    input  logic [TBL_IDX_W-1:0]  t2_index_i,
    input  logic [TAG_W-1:0]      t2_tag_i,
    input  logic                  base_pred_i,
    bp_table_if.ctrl              t1,
    bp_table_if.ctrl              t2,
    output logic                  base_upd_valid_o,
    output logic [BASE_IDX_W-1:0] base_upd_index_o,
    output logic                  base_inc_o,
    output logic [GHR_W-1:0]      ghr_o,
    output logic                  taken_o,
    output provider_e             provider_o
);

    logic [GHR_W-1:0] ghr;
    provider_e        provider;
    logic             prov_pred;
    logic             alt_pred;
    lookup_rec_t      new_rec;
    lookup_rec_t      upd_rec;
    logic             upd_found;
    logic             upd_hit;
    logic             mispred;
    logic             useful_chg;

    // Longest hitting history provides and the next hitting one is the alternate
    always_comb begin
        provider  = PROV_BASE;
        prov_pred = base_pred_i;
        alt_pred  = base_pred_i;
        if (t2_hit_i) begin
            provider  = PROV_T2;
            prov_pred = t2_pred_i;
            alt_pred  = t1_hit_i ? t1_pred_i : base_pred_i;
        end else if (t1_hit_i) begin
            provider  = PROV_T1;
            prov_pred = t1_pred_i;
        end
    end

    assign taken_o    = prov_pred;
    assign provider_o = provider;
    assign ghr_o      = ghr;

    // Speculative history that is never repaired
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (predict_valid_i) begin
            ghr <= {ghr[GHR_W-2:0], taken_o};
        end
    end

    always_comb begin
        new_rec.valid     = predict_valid_i;
        new_rec.pc        = pc_i;
        new_rec.t1_index  = t1_index_i;
        new_rec.t1_tag    = t1_tag_i;
        new_rec.t2_index  = t2_index_i;
        new_rec.t2_tag    = t2_tag_i;
        new_rec.provider  = provider;
        new_rec.prov_pred = prov_pred;
        new_rec.alt_pred  = alt_pred;
    end

    inflight_buffer u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (predict_valid_i),
        .rec_i       (new_rec),
        .lookup_pc_i (update_pc_i),
        .found_o     (upd_found),
        .rec_o       (upd_rec)
    );

    assign upd_hit    = update_valid_i && upd_found;
    assign mispred    = (upd_rec.prov_pred != update_taken_i);
    assign useful_chg = (upd_rec.prov_pred != upd_rec.alt_pred);

    // Base only trains when it was the provider
    assign base_upd_valid_o = upd_hit && (upd_rec.provider == PROV_BASE);
    assign base_upd_index_o = upd_rec.pc[BASE_IDX_W-1:0];
    assign base_inc_o       = update_taken_i;

    assign t1.upd_valid  = upd_hit;
    assign t1.upd_index  = upd_rec.t1_index;
    assign t1.upd_tag    = upd_rec.t1_tag;
    assign t1.upd_ctr    = upd_hit && (upd_rec.provider == PROV_T1);
    assign t1.inc_ctr    = update_taken_i;
    assign t1.upd_useful = upd_hit && (upd_rec.provider == PROV_T1) && useful_chg;
    assign t1.inc_useful = !mispred;
    assign t1.realloc    = upd_hit && mispred && (upd_rec.provider == PROV_BASE)
                           && (t1.upd_useful_q == '0);

    assign t2.upd_valid  = upd_hit;
    assign t2.upd_index  = upd_rec.t2_index;
    assign t2.upd_tag    = upd_rec.t2_tag;
    assign t2.upd_ctr    = upd_hit && (upd_rec.provider == PROV_T2);
    assign t2.inc_ctr    = update_taken_i;
    assign t2.upd_useful = upd_hit && (upd_rec.provider == PROV_T2) && useful_chg;
    assign t2.inc_useful = !mispred;
    // T2 takes the allocation when T1 is the provider or its entry is still useful
    assign t2.realloc    = upd_hit && mispred && (t2.upd_useful_q == '0)
                           && ((upd_rec.provider == PROV_T1)
                               || (upd_rec.provider == PROV_BASE && t1.upd_useful_q != '0));

    // One update allocates in at most one tagged table
    a_single_alloc: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(t1.realloc && t2.realloc)
    );

endmodule

// ==== hw/inflight_buffer.sv ====
// Shift buffer of prediction records, searched by PC when a branch outcome comes back
`timescale 1ns/1ps

module inflight_buffer
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push_i,
    input  lookup_rec_t     rec_i,
    input  logic [PC_W-1:0] lookup_pc_i,
    output logic            found_o,
    output lookup_rec_t     rec_o
);

    // Slot 0 is the youngest record
    lookup_rec_t                    slots [BUF_DEPTH];
    logic [BUF_DEPTH-1:0]           match;
    logic [$clog2(BUF_DEPTH)-1:0]   sel;

    // Shifts every cycle so a record ages out after BUF_DEPTH edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                slots[i] <= '0;
            end
        end else begin
            slots[0]       <= rec_i;
            slots[0].valid <= push_i;
            for (int i = 1; i < BUF_DEPTH; i++) begin
                slots[i] <= slots[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            match[i] = slots[i].valid && (slots[i].pc == lookup_pc_i);
        end
    end

    // Lowest matching slot wins
    always_comb begin
        sel = '0;
        for (int i = BUF_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = i[$clog2(BUF_DEPTH)-1:0];
            end
        end
    end

    assign found_o = |match;
    assign rec_o   = slots[sel];

    a_found_is_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        found_o |-> (rec_o.valid && rec_o.pc == lookup_pc_i)
    );

endmodule

// ==== hw/tagged_table.sv ====
// One TAGE tagged table: hashed lookup plus counter, useful and reallocation updates
`timescale 1ns/1ps

module tagged_table
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
#(
    parameter int HIST_LEN = T1_HIST
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [HIST_LEN-1:0]  ghr_i,
    input  logic [PC_W-1:0]      pc_i,
    output logic                 hit_o,
    output logic                 pred_o,
    output logic [TBL_IDX_W-1:0] index_o,
    output logic [TAG_W-1:0]     tag_o,
    bp_table_if.tbl              upd
);

    tagged_entry_t mem [2**TBL_IDX_W];

    logic [TBL_IDX_W-1:0] idx_fold;
    logic [TAG_W-1:0]     tag_fold;
    logic [TAG_W-2:0]     tag_fold_short;
    tagged_entry_t        q_entry;
    tagged_entry_t        upd_cur;
    tagged_entry_t        upd_nxt;

    // Three independent folds of the same history
    history_fold #(.IN_LEN(HIST_LEN), .OUT_LEN(TBL_IDX_W)) u_fold_idx (
        .hist_i (ghr_i),
        .fold_o (idx_fold)
    );

    history_fold #(.IN_LEN(HIST_LEN), .OUT_LEN(TAG_W)) u_fold_tag (
        .hist_i (ghr_i),
        .fold_o (tag_fold)
    );

    history_fold #(.IN_LEN(HIST_LEN), .OUT_LEN(TAG_W-1)) u_fold_tag_short (
        .hist_i (ghr_i),
        .fold_o (tag_fold_short)
    );

    assign index_o = idx_fold ^ pc_i[TBL_IDX_W-1:0] ^ pc_i[2*TBL_IDX_W-1:TBL_IDX_W];
    // Shifted second fold keeps the two tag hashes from cancelling
    assign tag_o   = pc_i[TAG_W-1:0] ^ tag_fold ^ {tag_fold_short, 1'b0};

    assign q_entry = mem[index_o];
    assign hit_o   = (q_entry.tag == tag_o);
    assign pred_o  = q_entry.ctr[CTR_W-1];

    assign upd_cur          = mem[upd.upd_index];
    assign upd.upd_useful_q = upd_cur.useful;

    always_comb begin
        upd_nxt = upd_cur;
        if (upd.upd_ctr) begin
            if (upd.inc_ctr && upd_cur.ctr != '1) begin
                upd_nxt.ctr = upd_cur.ctr + 1'b1;
            end else if (!upd.inc_ctr && upd_cur.ctr != '0) begin
                upd_nxt.ctr = upd_cur.ctr - 1'b1;
            end
        end
        if (upd.upd_useful) begin
            if (upd.inc_useful && upd_cur.useful != '1) begin
                upd_nxt.useful = upd_cur.useful + 1'b1;
            end else if (!upd.inc_useful && upd_cur.useful != '0) begin
                upd_nxt.useful = upd_cur.useful - 1'b1;
            end
        end
        // Fresh entry overrides any training on the old one
        if (upd.realloc && upd_cur.tag != upd.upd_tag) begin
            upd_nxt.tag    = upd.upd_tag;
            upd_nxt.ctr    = {1'b1, {(CTR_W-1){1'b0}}};
            upd_nxt.useful = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**TBL_IDX_W; i++) begin
                mem[i].ctr    <= {1'b1, {(CTR_W-1){1'b0}}};
                mem[i].tag    <= '0;
                mem[i].useful <= '0;
            end
        end else if (upd.upd_valid) begin
            mem[upd.upd_index] <= upd_nxt;
        end
    end

    // Control only asks for a new entry on a matched update
    a_realloc_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) upd.realloc |-> upd.upd_valid
    );

endmodule

// ==== hw/base_table.sv ====
// Bimodal base predictor of 2-bit saturating counters, indexed by the low PC bits
`timescale 1ns/1ps

module base_table
    import bp_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [PC_W-1:0]       pc_i,
    output logic                  pred_o,
    input  logic                  upd_valid_i,
    input  logic [BASE_IDX_W-1:0] upd_index_i,
    input  logic                  inc_i
);

    logic [BASE_CTR_W-1:0] ctr_mem [2**BASE_IDX_W];
    logic [BASE_CTR_W-1:0] upd_cur;
    logic [BASE_CTR_W-1:0] upd_nxt;

    // Direction is the counter MSB
    assign pred_o = ctr_mem[pc_i[BASE_IDX_W-1:0]][BASE_CTR_W-1];

    // Saturating step toward the outcome
    assign upd_cur = ctr_mem[upd_index_i];
    always_comb begin
        upd_nxt = upd_cur;
        if (inc_i && upd_cur != '1) begin
            upd_nxt = upd_cur + 1'b1;
        end else if (!inc_i && upd_cur != '0) begin
            upd_nxt = upd_cur - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Weakly taken
            for (int i = 0; i < 2**BASE_IDX_W; i++) begin
                ctr_mem[i] <= {1'b1, {(BASE_CTR_W-1){1'b0}}};
            end
        end else if (upd_valid_i) begin
            ctr_mem[upd_index_i] <= upd_nxt;
        end
    end

endmodule

// ==== hw/history_fold.sv ====
// Combinational XOR fold of a history slice down to a hash width, used by the tagged tables
`timescale 1ns/1ps

module history_fold
    import bp_cfg_pkg::*;
#(
    parameter int IN_LEN  = GHR_W,
    parameter int OUT_LEN = TBL_IDX_W
) (
    input  logic [IN_LEN-1:0]  hist_i,
    output logic [OUT_LEN-1:0] fold_o
);

    // Bit b lands in chunk b / OUT_LEN at position b % OUT_LEN.
    // Bits past the end of the last chunk are simply absent, which is
    // the same as zero padding.
    always_comb begin
        fold_o = '0;
        for (int b = 0; b < IN_LEN; b++) begin
            fold_o[b % OUT_LEN] = fold_o[b % OUT_LEN] ^ hist_i[b];
        end
    end

endmodule

// ==== hw/bp_table_if.sv ====
// Update and useful-query channel from the TAGE control to one tagged table
`timescale 1ns/1ps

interface bp_table_if import bp_cfg_pkg::*; ();

    logic                 upd_valid;
    logic [TBL_IDX_W-1:0] upd_index;
    logic [TAG_W-1:0]     upd_tag;
    logic                 upd_ctr;
    logic                 inc_ctr;
    logic                 upd_useful;
    logic                 inc_useful;
    logic                 realloc;
    // Useful value at upd_index, read without a clock
    logic [USE_W-1:0]     upd_useful_q;

    modport ctrl (
        output upd_valid, upd_index, upd_tag, upd_ctr, inc_ctr,
        output upd_useful, inc_useful, realloc,
        input  upd_useful_q
    );

    modport tbl (
        input  upd_valid, upd_index, upd_tag, upd_ctr, inc_ctr,
        input  upd_useful, inc_useful, realloc,
        output upd_useful_q
    );

endinterface

// ==== hw/bp_types_pkg.sv ====
// Table entry, lookup record and provider types shared by the control, buffer and tables
package bp_types_pkg;

    import bp_cfg_pkg::*;

    // One tagged table slot
    typedef struct packed {
        logic [CTR_W-1:0] ctr;
        logic [TAG_W-1:0] tag;
        logic [USE_W-1:0] useful;
    } tagged_entry_t;

    // Which component supplied the final prediction
    typedef enum logic [1:0] {
        PROV_BASE = 2'd0,
        PROV_T1   = 2'd1,
        PROV_T2   = 2'd2
    } provider_e;

    // Everything needed to train the tables once the outcome is known
    typedef struct packed {
        logic                 valid;
        logic [PC_W-1:0]      pc;
        logic [TBL_IDX_W-1:0] t1_index;
        logic [TAG_W-1:0]     t1_tag;
        logic [TBL_IDX_W-1:0] t2_index;
        logic [TAG_W-1:0]     t2_tag;
        provider_e            provider;
        logic                 prov_pred;
        logic                 alt_pred;
    } lookup_rec_t;

endpackage

// ==== hw/bp_cfg_pkg.sv ====
// Sizing constants for the tage_lite predictor, imported by every RTL block
package bp_cfg_pkg;

    // Fetch address and global history
    localparam int PC_W    = 32;
    localparam int GHR_W   = 16;

    // History lengths seen by the two tagged tables
    localparam int T1_HIST = 5;
    localparam int T2_HIST = 15;

    // Tagged table geometry, 128 entries each
    localparam int TBL_IDX_W = 7;
    localparam int TAG_W     = 8;
    localparam int CTR_W     = 3;
    localparam int USE_W     = 2;

    // Bimodal base table, indexed straight from the low PC bits
    localparam int BASE_IDX_W = 8;
    localparam int BASE_CTR_W = 2;

    // Records kept while the outcome is pending
    localparam int BUF_DEPTH = 8;

endpackage
